/* hdl/ctrlUnit_params.svh */
`ifndef CTRLUNIT_PARAMS_SVH
`define CTRLUNIT_PARAMS_SVH

////////////////////
// Instruction set widths
////////////////////

`define INSTR_WIDTH 16
`define REG_SEL_WIDTH 5
`define ALU_OP_WIDTH 8
`define BRANCH_OFF_WIDTH 10

////////////////////
// Register select encodings
////////////////////

// One past the last register, no buffer or write enabled
`define NO_REG 5'd16

`endif

/* hdl/ctrlUnitPkg.sv */
`default_nettype none
`include "ctrlUnit_params.svh"

package ctrlUnitPkg;

	////////////////////
	// FSM and opcodes
	////////////////////

	typedef enum logic [3:0] {
		stFetch = 4'd0,
		stDecode = 4'd1,
		stExecute = 4'd2,
		stLoadData = 4'd3,
		stLoadExecute = 4'd4,
		stStore = 4'd5,
		stBranch = 4'd6,
		stJump = 4'd7
	} stateT;

	typedef enum logic [3:0] {
		opRType = 4'b0000,
		opAndI = 4'b0001,
		opOrI = 4'b0010,
		opXorI = 4'b0011,
		opMemJump = 4'b0100, // Load, store and jump share this, split by bits 7:4
		opAddI = 4'b0101,
		opShift = 4'b1000,
		opSubI = 4'b1001,
		opCmpI = 4'b1011,
		opBranch = 4'b1100,
		opMovI = 4'b1101
	} opcodeT;

	typedef enum logic [2:0] {
		clsAluReg,
		clsAluImm,
		clsLoad,
		clsStore,
		clsBranch,
		clsJump
	} opClassT;

	typedef enum logic [3:0] {
		condEq = 4'b0000,
		condNe = 4'b0001,
		condCs = 4'b0010,
		condCc = 4'b0011,
		condHi = 4'b0100,
		condLs = 4'b0101,
		condGt = 4'b0110,
		condLe = 4'b0111,
		condFs = 4'b1000,
		condFc = 4'b1001,
		condLo = 4'b1010,
		condHs = 4'b1011,
		condLt = 4'b1100,
		condGe = 4'b1101
	} condT;

	////////////////////
	// Bundles
	////////////////////

	typedef struct packed {
		logic negative;
		logic zero;
		logic flag;
		logic low;
		logic carry;
	} flagsT;

	typedef struct packed {
		opClassT opClass;
		logic [`REG_SEL_WIDTH-1:0] rdst;
		logic [`REG_SEL_WIDTH-1:0] rsrc;
		logic [`ALU_OP_WIDTH-1:0] aluOp;
		logic [`INSTR_WIDTH-1:0] imm;
		logic writesDest; // Low for compares
		condT cond;
		logic [`BRANCH_OFF_WIDTH-1:0] branchOffset;
	} decodedT;

	typedef struct packed {
		logic [`REG_SEL_WIDTH-1:0] regEn;
		logic [`REG_SEL_WIDTH-1:0] bufEnA;
		logic [`REG_SEL_WIDTH-1:0] bufEnB;
		logic [`ALU_OP_WIDTH-1:0] aluOp;
		logic aluResultEn;
		logic immEn;
		logic [`INSTR_WIDTH-1:0] imm;
		logic memReadEn;
		logic memOutEn;
		logic memWe;
		logic [`BRANCH_OFF_WIDTH-1:0] branchOffset;
		logic branchEn;
		logic jumpEn;
		logic pcEn;
		logic pcAddrEn; // Memory address from PC
		logic regAddrEn; // Memory address from register
	} ctrlWordT;

endpackage

`default_nettype wire

/* hdl/instrDecoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ctrlUnit_params.svh"

module instrDecoder (
	input logic clk,
	input logic reset,
	input logic [`INSTR_WIDTH-1:0] instruction,
	input logic latchInstr,
	output ctrlUnitPkg::opClassT incomingClass,
	output ctrlUnitPkg::decodedT decoded
);

	ctrlUnitPkg::opcodeT opcode;
	logic [3:0] ext;
	logic shiftImm;
	logic signedImm;
	logic isCompare;
	ctrlUnitPkg::decodedT fields;

	assign opcode = ctrlUnitPkg::opcodeT'(instruction[15:12]);
	assign ext = instruction[7:4]; // Function field

	// Shift with an immediate amount
	assign shiftImm = (opcode == ctrlUnitPkg::opShift) && (instruction[11:9] == 3'b001);

	assign signedImm = (opcode == ctrlUnitPkg::opAddI) ||
		(opcode == ctrlUnitPkg::opSubI) ||
		(opcode == ctrlUnitPkg::opCmpI);

	assign isCompare = (opcode == ctrlUnitPkg::opCmpI) ||
		((opcode == ctrlUnitPkg::opRType) && (ext == 4'b1011));

	////////////////////
	// Classify live bus
	////////////////////

	always_comb begin
		case (opcode)
			ctrlUnitPkg::opMemJump: begin
				case (ext)
					4'b0000: incomingClass = ctrlUnitPkg::clsLoad;
					4'b0100: incomingClass = ctrlUnitPkg::clsStore;
					4'b1100: incomingClass = ctrlUnitPkg::clsJump;
					default: incomingClass = ctrlUnitPkg::clsAluReg;
				endcase
			end
			ctrlUnitPkg::opBranch: begin
				incomingClass = ctrlUnitPkg::clsBranch;
			end
			ctrlUnitPkg::opAndI,
			ctrlUnitPkg::opOrI,
			ctrlUnitPkg::opXorI,
			ctrlUnitPkg::opAddI,
			ctrlUnitPkg::opSubI,
			ctrlUnitPkg::opCmpI,
			ctrlUnitPkg::opMovI: begin
				incomingClass = ctrlUnitPkg::clsAluImm;
			end
			ctrlUnitPkg::opShift: begin
				incomingClass = shiftImm ? ctrlUnitPkg::clsAluImm : ctrlUnitPkg::clsAluReg;
			end
			default: begin
				incomingClass = ctrlUnitPkg::clsAluReg; // R-type and unknown opcodes
			end
		endcase
	end

	////////////////////
	// Field decode
	////////////////////

	always_comb begin
		fields.opClass = incomingClass;
		fields.rdst = {{(`REG_SEL_WIDTH-4){1'b0}}, instruction[11:8]};
		fields.rsrc = {{(`REG_SEL_WIDTH-4){1'b0}}, instruction[3:0]};

		if (signedImm) begin
			fields.imm = {{(`INSTR_WIDTH-8){instruction[7]}}, instruction[7:0]};
		end
		else begin
			fields.imm = {{(`INSTR_WIDTH-8){1'b0}}, instruction[7:0]};
		end

		if (incomingClass == ctrlUnitPkg::clsAluImm) begin
			if (shiftImm) begin
				fields.aluOp = '0;
			end
			else begin
				fields.aluOp = {4'd0, instruction[15:12]};
			end
		end
		else begin
			fields.aluOp = {instruction[15:12], ext};
		end

		fields.writesDest = !isCompare;
		fields.cond = ctrlUnitPkg::condT'(instruction[11:8]);
		fields.branchOffset = {{(`BRANCH_OFF_WIDTH-8){instruction[7]}}, instruction[7:0]};
	end

	// Held for the work states
	always_ff @(posedge clk) begin
		if (reset) begin
			decoded <= '0;
		end
		else if (latchInstr) begin
			decoded <= fields;
		end
	end

endmodule

`default_nettype wire

/* hdl/stateSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module stateSequencer (
	input logic clk,
	input logic reset,
	input ctrlUnitPkg::opClassT incomingClass,
	output ctrlUnitPkg::stateT state,
	output logic latchInstr
);

	ctrlUnitPkg::stateT nextState;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrlUnitPkg::stFetch;
		end
		else begin
			state <= nextState;
		end
	end

	////////////////////
	// Transitions
	////////////////////

	always_comb begin
		case (state)
			ctrlUnitPkg::stFetch: begin
				nextState = ctrlUnitPkg::stDecode;
			end
			ctrlUnitPkg::stDecode: begin
				case (incomingClass)
					ctrlUnitPkg::clsLoad: nextState = ctrlUnitPkg::stLoadData;
					ctrlUnitPkg::clsStore: nextState = ctrlUnitPkg::stStore;
					ctrlUnitPkg::clsBranch: nextState = ctrlUnitPkg::stBranch;
					ctrlUnitPkg::clsJump: nextState = ctrlUnitPkg::stJump;
					default: nextState = ctrlUnitPkg::stExecute; // Both ALU classes
				endcase
			end
			ctrlUnitPkg::stLoadData: begin
				nextState = ctrlUnitPkg::stLoadExecute; // Second load cycle
			end
			default: begin
				nextState = ctrlUnitPkg::stFetch;
			end
		endcase
	end

	// Decoder samples the bus on the edge leaving decode
	assign latchInstr = (state == ctrlUnitPkg::stDecode);

endmodule

`default_nettype wire

/* hdl/controlEncoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ctrlUnit_params.svh"

module controlEncoder (
	input ctrlUnitPkg::stateT state,
	input ctrlUnitPkg::decodedT decoded,
	input ctrlUnitPkg::flagsT flags,
	output ctrlUnitPkg::ctrlWordT ctrl
);

	logic taken;

	////////////////////
	// Condition codes
	////////////////////

	always_comb begin
		case (decoded.cond)
			ctrlUnitPkg::condEq: taken = flags.zero;
			ctrlUnitPkg::condNe: taken = !flags.zero;
			ctrlUnitPkg::condCs: taken = flags.carry;
			ctrlUnitPkg::condCc: taken = !flags.carry;
			ctrlUnitPkg::condHi: taken = flags.low;
			ctrlUnitPkg::condLs: taken = !flags.low;
			ctrlUnitPkg::condGt: taken = flags.negative;
			ctrlUnitPkg::condLe: taken = !flags.negative;
			ctrlUnitPkg::condLo: taken = !flags.low && !flags.zero;
			ctrlUnitPkg::condHs: taken = flags.low || flags.zero;
			ctrlUnitPkg::condLt: taken = !flags.negative && !flags.zero;
			ctrlUnitPkg::condGe: taken = flags.negative || flags.zero;
			ctrlUnitPkg::condFs,
			ctrlUnitPkg::condFc: taken = 1'b0; // Flag conditions not supported
			default: taken = 1'b0;
		endcase
	end

	////////////////////
	// Control word
	////////////////////

	always_comb begin
		ctrl = '0;
		ctrl.regEn = `NO_REG;
		ctrl.pcAddrEn = 1'b1; // Fetch address

		case (state)
			ctrlUnitPkg::stExecute: begin
				ctrl.aluResultEn = 1'b1;
				ctrl.aluOp = decoded.aluOp;
				ctrl.pcEn = 1'b1;
				ctrl.bufEnA = decoded.rdst;
				ctrl.regEn = decoded.writesDest ? decoded.rdst : `NO_REG;
				if (decoded.opClass == ctrlUnitPkg::clsAluImm) begin
					ctrl.immEn = 1'b1;
					ctrl.imm = decoded.imm;
					ctrl.bufEnB = `NO_REG; // Immediate takes port B
				end
				else begin
					ctrl.bufEnB = decoded.rsrc;
				end
			end

			ctrlUnitPkg::stLoadData: begin
				ctrl.memReadEn = 1'b1;
				ctrl.bufEnA = decoded.rsrc; // Address register
				ctrl.bufEnB = `NO_REG;
				ctrl.regAddrEn = 1'b1;
				ctrl.pcAddrEn = 1'b0;
			end

			ctrlUnitPkg::stLoadExecute: begin
				ctrl.memReadEn = 1'b1;
				ctrl.memOutEn = 1'b1;
				ctrl.regEn = decoded.rdst; // Write back loaded data
				ctrl.bufEnA = decoded.rsrc;
				ctrl.bufEnB = `NO_REG;
				ctrl.pcEn = 1'b1;
			end

			ctrlUnitPkg::stStore: begin
				ctrl.memWe = 1'b1;
				ctrl.bufEnA = decoded.rsrc; // Address
				ctrl.bufEnB = decoded.rdst; // Data
				ctrl.regAddrEn = 1'b1;
				ctrl.pcAddrEn = 1'b0;
				ctrl.pcEn = 1'b1;
			end

			ctrlUnitPkg::stBranch: begin
				ctrl.bufEnA = `NO_REG;
				ctrl.bufEnB = `NO_REG;
				ctrl.branchOffset = decoded.branchOffset;
				ctrl.branchEn = taken;
				ctrl.pcEn = !taken; // Plain increment when not taken
			end

			ctrlUnitPkg::stJump: begin
				ctrl.bufEnA = `NO_REG;
				ctrl.bufEnB = decoded.rsrc; // Target register
				ctrl.jumpEn = taken;
				ctrl.pcEn = !taken;
			end

			default: begin
				// Fetch and decode keep the idle word
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/ctrlUnit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ctrlUnit_params.svh"

module ctrlUnit (
	input logic clk,
	input logic reset,
	input logic [`INSTR_WIDTH-1:0] instruction,
	input ctrlUnitPkg::flagsT flags,
	output ctrlUnitPkg::ctrlWordT ctrl
);

	ctrlUnitPkg::stateT state;
	ctrlUnitPkg::opClassT incomingClass;
	ctrlUnitPkg::decodedT decoded;
	logic latchInstr;

	////////////////////
	// Input side
	////////////////////

	instrDecoder uDecoder (
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.latchInstr(latchInstr),
		.incomingClass(incomingClass),
		.decoded(decoded)
	);

	stateSequencer uSequencer (
		.clk(clk),
		.reset(reset),
		.incomingClass(incomingClass),
		.state(state),
		.latchInstr(latchInstr)
	);

	////////////////////
	// Output side
	////////////////////

	controlEncoder uEncoder (
		.state(state),
		.decoded(decoded),
		.flags(flags),
		.ctrl(ctrl)
	);

endmodule

`default_nettype wire

/* tb/ctrlRefModel.svh */
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

////////////////////
// Instruction classes
////////////////////

function automatic ctrlUnitPkg::opClassT classify(input logic [`INSTR_WIDTH-1:0] instr);
	logic [3:0] op;
	logic [3:0] ext;
	ctrlUnitPkg::opClassT cls;
	op = instr[15:12];
	ext = instr[7:4];
	if (op == 4'b0100) begin
		cls = (ext == 4'b0000) ? ctrlUnitPkg::clsLoad :
			(ext == 4'b0100) ? ctrlUnitPkg::clsStore :
			(ext == 4'b1100) ? ctrlUnitPkg::clsJump : ctrlUnitPkg::clsAluReg;
	end
	else if (op == 4'b1100) begin
		cls = ctrlUnitPkg::clsBranch;
	end
	else if ((op inside {4'b0001, 4'b0010, 4'b0011, 4'b0101, 4'b1001, 4'b1011, 4'b1101}) ||
		(op == 4'b1000 && instr[11:9] == 3'b001)) begin
		cls = ctrlUnitPkg::clsAluImm; // Immediate forms and shift by constant
	end
	else begin
		cls = ctrlUnitPkg::clsAluReg;
	end
	return cls;
endfunction

function automatic ctrlUnitPkg::stateT nextPhase(input ctrlUnitPkg::stateT phase,
		input logic [`INSTR_WIDTH-1:0] instr);
	ctrlUnitPkg::stateT nxt;
	case (phase)
		ctrlUnitPkg::stFetch: nxt = ctrlUnitPkg::stDecode;
		ctrlUnitPkg::stDecode: begin
			case (classify(instr))
				ctrlUnitPkg::clsLoad: nxt = ctrlUnitPkg::stLoadData;
				ctrlUnitPkg::clsStore: nxt = ctrlUnitPkg::stStore;
				ctrlUnitPkg::clsBranch: nxt = ctrlUnitPkg::stBranch;
				ctrlUnitPkg::clsJump: nxt = ctrlUnitPkg::stJump;
				default: nxt = ctrlUnitPkg::stExecute;
			endcase
		end
		ctrlUnitPkg::stLoadData: nxt = ctrlUnitPkg::stLoadExecute;
		default: nxt = ctrlUnitPkg::stFetch; // Every other work state ends here
	endcase
	return nxt;
endfunction

////////////////////
// Expected control word
////////////////////

function automatic logic conditionTaken(input logic [3:0] cond, input ctrlUnitPkg::flagsT f);
	logic t;
	case (cond)
		4'd0: t = f.zero;
		4'd1: t = !f.zero;
		4'd2: t = f.carry;
		4'd3: t = !f.carry;
		4'd4: t = f.low;
		4'd5: t = !f.low;
		4'd6: t = f.negative;
		4'd7: t = !f.negative;
		4'd10: t = !f.low && !f.zero;
		4'd11: t = f.low || f.zero;
		4'd12: t = !f.negative && !f.zero;
		4'd13: t = f.negative || f.zero;
		default: t = 1'b0; // FS, FC and the two spare codes
	endcase
	return t;
endfunction

function automatic ctrlUnitPkg::ctrlWordT expectedCtrl(input ctrlUnitPkg::stateT phase,
		input logic [`INSTR_WIDTH-1:0] instr, input ctrlUnitPkg::flagsT f);
	ctrlUnitPkg::ctrlWordT w;
	logic [3:0] op;
	logic [`REG_SEL_WIDTH-1:0] rd;
	logic [`REG_SEL_WIDTH-1:0] rs;
	logic taken;
	logic isCompare;
	op = instr[15:12];
	rd = {1'b0, instr[11:8]};
	rs = {1'b0, instr[3:0]};
	taken = conditionTaken(instr[11:8], f);
	isCompare = (op == 4'b1011) || (op == 4'b0000 && instr[7:4] == 4'b1011);
	w = '0;
	w.regEn = `NO_REG;
	w.pcAddrEn = 1'b1;
	case (phase)
		ctrlUnitPkg::stExecute: begin
			w.aluResultEn = 1'b1;
			w.pcEn = 1'b1;
			w.bufEnA = rd;
			w.regEn = isCompare ? `NO_REG : rd;
			if (classify(instr) == ctrlUnitPkg::clsAluImm) begin
				w.immEn = 1'b1;
				w.bufEnB = `NO_REG;
				w.aluOp = (op == 4'b1000) ? 8'h00 : {4'h0, op};
				w.imm = (op inside {4'b0101, 4'b1001, 4'b1011}) ?
					{{8{instr[7]}}, instr[7:0]} : {8'h00, instr[7:0]};
			end
			else begin
				w.bufEnB = rs;
				w.aluOp = {op, instr[7:4]};
			end
		end
		ctrlUnitPkg::stLoadData: begin
			w.memReadEn = 1'b1;
			w.bufEnA = rs;
			w.bufEnB = `NO_REG;
			w.regAddrEn = 1'b1;
			w.pcAddrEn = 1'b0;
		end
		ctrlUnitPkg::stLoadExecute: begin
			w.memReadEn = 1'b1;
			w.memOutEn = 1'b1;
			w.regEn = rd;
			w.bufEnA = rs;
			w.bufEnB = `NO_REG;
			w.pcEn = 1'b1;
		end
		ctrlUnitPkg::stStore: begin
			w.memWe = 1'b1;
			w.bufEnA = rs;
			w.bufEnB = rd;
			w.regAddrEn = 1'b1;
			w.pcAddrEn = 1'b0;
			w.pcEn = 1'b1;
		end
		ctrlUnitPkg::stBranch: begin
			w.bufEnA = `NO_REG;
			w.bufEnB = `NO_REG;
			w.branchOffset = {{2{instr[7]}}, instr[7:0]};
			w.branchEn = taken;
			w.pcEn = !taken;
		end
		ctrlUnitPkg::stJump: begin
			w.bufEnA = `NO_REG;
			w.bufEnB = rs;
			w.jumpEn = taken;
			w.pcEn = !taken;
		end
		default: begin
			// Fetch and decode
		end
	endcase
	return w;
endfunction

`endif

/* tb/tbCtrlUnit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "ctrlUnit_params.svh"

module tbCtrlUnit;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int INSTR_COUNT = 2000;
	localparam int TIMEOUT_NS = INSTR_COUNT * 4 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

	logic clk;
	logic reset;
	logic [`INSTR_WIDTH-1:0] instruction;
	ctrlUnitPkg::flagsT flags;
	ctrlUnitPkg::ctrlWordT ctrl;

	ctrlUnitPkg::stateT modelPhase;
	logic [`INSTR_WIDTH-1:0] heldInstr; // Copy of the decoder register
	logic [31:0] rngState;
	int doneCount = 0;
	int checkCount = 0;
	int errorCount = 0;

	`include "ctrlRefModel.svh"

	ctrlUnit i_ctrlUnit (
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.flags(flags),
		.ctrl(ctrl)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Leans the mix toward the rarer classes
	function automatic logic [`INSTR_WIDTH-1:0] shapeInstruction(input logic [31:0] r);
		logic [`INSTR_WIDTH-1:0] instr;
		case (r[31:28])
			4'd0, 4'd1: instr = {4'b0100, r[11:8], 4'b0000, r[3:0]}; // Load
			4'd2: instr = {4'b0100, r[11:8], 4'b0100, r[3:0]}; // Store
			4'd3, 4'd4: instr = {4'b0100, r[11:8], 4'b1100, r[3:0]}; // Jump
			4'd5, 4'd6: instr = {4'b1100, r[11:0]};
			4'd7: instr = {4'b1000, 3'b001, r[8:0]}; // Shift immediate
			4'd8: instr = {4'b0000, r[11:8], 4'b1011, r[3:0]}; // Register compare
			4'd9: instr = {4'b1011, r[11:0]};
			default: instr = r[15:0];
		endcase
		return instr;
	endfunction

	function automatic string testName(input logic inReset, input ctrlUnitPkg::stateT phase,
			input logic [`INSTR_WIDTH-1:0] instr);
		string name;
		case (phase)
			ctrlUnitPkg::stFetch: name = "fetch";
			ctrlUnitPkg::stDecode: name = "decode";
			ctrlUnitPkg::stExecute: begin
				name = (classify(instr) == ctrlUnitPkg::clsAluImm) ? "alu imm" : "alu reg";
			end
			ctrlUnitPkg::stLoadData, ctrlUnitPkg::stLoadExecute: name = "load";
			ctrlUnitPkg::stStore: name = "store";
			ctrlUnitPkg::stBranch: name = "branch";
			ctrlUnitPkg::stJump: name = "jump";
			default: name = "unknown";
		endcase
		return inReset ? "reset" : name;
	endfunction

	task automatic checkField(input string test, input string field,
			input logic [15:0] expVal, input logic [15:0] actVal);
		checkCount++;
		assert (actVal === expVal)
		else begin
			errorCount++;
			$display("** Error: %s, %s expected %h, actual %h at %0t",
				test, field, expVal, actVal, $time);
		end
	endtask

	task automatic compareCtrl();
		ctrlUnitPkg::ctrlWordT want;
		string test;
		want = expectedCtrl(modelPhase, heldInstr, flags);
		test = testName(reset, modelPhase, heldInstr);
		checkField(test, "regEn", 16'(want.regEn), 16'(ctrl.regEn));
		checkField(test, "bufEnA", 16'(want.bufEnA), 16'(ctrl.bufEnA));
		checkField(test, "bufEnB", 16'(want.bufEnB), 16'(ctrl.bufEnB));
		checkField(test, "aluOp", 16'(want.aluOp), 16'(ctrl.aluOp));
		checkField(test, "aluResultEn", 16'(want.aluResultEn), 16'(ctrl.aluResultEn));
		checkField(test, "immEn", 16'(want.immEn), 16'(ctrl.immEn));
		checkField(test, "imm", want.imm, ctrl.imm);
		checkField(test, "memReadEn", 16'(want.memReadEn), 16'(ctrl.memReadEn));
		checkField(test, "memOutEn", 16'(want.memOutEn), 16'(ctrl.memOutEn));
		checkField(test, "memWe", 16'(want.memWe), 16'(ctrl.memWe));
		checkField(test, "branchOffset", 16'(want.branchOffset), 16'(ctrl.branchOffset));
		checkField(test, "branchEn", 16'(want.branchEn), 16'(ctrl.branchEn));
		checkField(test, "jumpEn", 16'(want.jumpEn), 16'(ctrl.jumpEn));
		checkField(test, "pcEn", 16'(want.pcEn), 16'(ctrl.pcEn));
		checkField(test, "pcAddrEn", 16'(want.pcAddrEn), 16'(ctrl.pcAddrEn));
		checkField(test, "regAddrEn", 16'(want.regAddrEn), 16'(ctrl.regAddrEn));
	endtask

	////////////////////
	// Stimulus and phase model
	////////////////////

	initial begin
		int cycleCount;
		clk = 1'b0;
		reset = 1'b1;
		instruction = '0;
		flags = '0;
		modelPhase = ctrlUnitPkg::stFetch;
		heldInstr = '0;
		rngState = 32'h258d;
		cycleCount = 0;
		while (doneCount < INSTR_COUNT) begin
			@(posedge clk);
			#0.5;
			cycleCount++;
			if (reset) begin
				modelPhase = ctrlUnitPkg::stFetch;
			end
			else begin
				if (modelPhase == ctrlUnitPkg::stDecode) begin
					heldInstr = instruction; // Decoder takes the bus on this edge
				end
				if (modelPhase inside {ctrlUnitPkg::stExecute, ctrlUnitPkg::stLoadExecute,
					ctrlUnitPkg::stStore, ctrlUnitPkg::stBranch, ctrlUnitPkg::stJump}) begin
					doneCount++;
				end
				modelPhase = nextPhase(modelPhase, instruction);
			end
			if (cycleCount == RESET_CYCLES) begin
				reset = 1'b0;
			end
			rngState = xorshift32(rngState);
			if (modelPhase == ctrlUnitPkg::stDecode) begin
				instruction = shapeInstruction(rngState);
			end
			else begin
				instruction = rngState[31:16]; // Bus only valid in decode
			end
			rngState = xorshift32(rngState);
			flags = ctrlUnitPkg::flagsT'(rngState[4:0]);
		end
		@(posedge clk); // Let the last compare run
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test completed successfully");
		end
		else begin
			$display("Test failed");
		end
		$finish;
	end

	// Sample just before the next edge
	always @(posedge clk) begin
		#3.5;
		compareCtrl();
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns, %0d of %0d instructions done, errors: %0d",
			TIMEOUT_NS, doneCount, INSTR_COUNT, errorCount);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* ctrlUnit.f */
+incdir+hdl
+incdir+tb
hdl/ctrlUnitPkg.sv
hdl/instrDecoder.sv
hdl/stateSequencer.sv
hdl/controlEncoder.sv
hdl/ctrlUnit.sv
tb/tbCtrlUnit.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/100ps -f ctrlUnit.f --top-module tbCtrlUnit &&
./obj_dir/VtbCtrlUnit | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
